//--- Makefile
# Verilator build and run for radio_core

VERILATOR ?= verilator
TOP       ?= radio_core_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FLIST     ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := verilog/radio_defs.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/radio_core_sva.sv
// timing assertions for radio_core strobes and output data, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module radio_core_sva (
   input wire        radio_clk,
   input wire        i_arst_n,
   input wire        i_rx_stb,
   input wire        o_rx_stb,
   input wire        i_rb_stb,
   input wire        o_rb_stb,
   input wire [31:0] o_rx_data
);

   // RX latency is exactly three cycles
   rx_latency_a : assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      i_rx_stb |-> ##3 o_rx_stb)
      else $error("o_rx_stb missing 3 cycles after i_rx_stb");

   rx_origin_a : assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_rx_stb |-> $past(i_rx_stb, 3))
      else $error("o_rx_stb without i_rx_stb 3 cycles earlier");

   // readback answers one cycle later
   rb_latency_a : assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      i_rb_stb |=> o_rb_stb)
      else $error("o_rb_stb missing after i_rb_stb");

   rb_origin_a : assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_rb_stb |-> $past(i_rb_stb))
      else $error("o_rb_stb without a request");

   rx_known_a : assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      o_rx_stb |-> !$isunknown(o_rx_data))
      else $error("o_rx_data has unknown bits");

endmodule : radio_core_sva

bind radio_core radio_core_sva u_radio_core_sva (
   .radio_clk (radio_clk),
   .i_arst_n  (i_arst_n),
   .i_rx_stb  (i_rx_stb),
   .o_rx_stb  (o_rx_stb),
   .i_rb_stb  (i_rb_stb),
   .o_rb_stb  (o_rb_stb),
   .o_rx_data (o_rx_data)
);

`default_nettype wire

//--- verification/radio_core_tb.sv
// radio_core testbench with clock, reset, stimulus table, reference model and checks
`timescale 1ns/1ps
`default_nettype none

`include "radio_defs.svh"

module radio_core_tb;

   localparam int K_WR = 0;   // settings write
   localparam int K_RB = 1;   // readback request
   localparam int K_RX = 2;   // RX samples back to back

   localparam logic [31:0] DB_IN   = 32'hcafe_f00d;
   localparam logic [11:0] FP_IN   = 12'h5a3;
   localparam logic [31:0] MISC_IN = 32'h1357_9bdf;

   logic                     radio_clk;
   logic                     i_arst_n;
   logic                     i_set_stb;
   logic [`SET_ADDR_W-1:0]   i_set_addr;
   logic [`SET_DATA_W-1:0]   i_set_data;
   logic                     i_rb_stb;
   logic [`SET_ADDR_W-1:0]   i_rb_addr;
   logic                     i_rx_stb;
   logic [`SAMPLE_W-1:0]     i_rx_data;
   logic [`GPIO_W-1:0]       i_db_gpio_in;
   logic [`FP_GPIO_W-1:0]    i_fp_gpio_in;
   logic [`GPIO_W-1:0]       i_misc_in;
   wire                      o_rb_stb;
   wire  [`SET_DATA_W-1:0]   o_rb_data;
   wire                      o_rx_stb;
   wire  [`SAMPLE_W-1:0]     o_rx_data;
   wire  [`GPIO_W-1:0]       o_db_gpio_out;
   wire  [`GPIO_W-1:0]       o_db_gpio_ddr;
   wire  [`FP_GPIO_W-1:0]    o_fp_gpio_out;
   wire  [`FP_GPIO_W-1:0]    o_fp_gpio_ddr;
   wire  [`GPIO_W-1:0]       o_misc_out;
   wire  [`LED_W-1:0]        o_leds;

   // shadow copy of the settings bank
   logic [2:0]   sh_ctrl;
   logic [15:0]  sh_scale;
   logic [31:0]  sh_thres;
   logic [11:0]  sh_fp_out;
   logic [31:0]  sh_db_out;
   logic [31:0]  sh_db_ddr;
   logic [11:0]  sh_fp_ddr;
   logic [31:0]  sh_misc;
   logic [2:0]   sh_leds;

   integer       seed;

   // stimulus table
   int           row_kind[$];
   logic [7:0]   row_addr[$];
   logic [31:0]  row_data[$];
   int           row_cnt[$];

   radio_core UUT (.*);

   initial radio_clk = 1'b0;
   always #5 radio_clk = ~radio_clk;

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   task automatic tick();
      @(posedge radio_clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("** Error at %0t ns: %s expected %h, got %h",
                  $time, name, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("timeout: %s never arrived", what);
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
   endtask

   task automatic add_row(input int kind, input logic [7:0] addr,
                          input logic [31:0] data, input int cnt);
      row_kind.push_back(kind);
      row_addr.push_back(addr);
      row_data.push_back(data);
      row_cnt.push_back(cnt);
   endtask

   // all pin outputs against the shadow bank
   task automatic check_pins();
      check_value("o_db_gpio_out", sh_db_out, o_db_gpio_out);
      check_value("o_db_gpio_ddr", sh_db_ddr, o_db_gpio_ddr);
      check_value("o_fp_gpio_out[11:1]", sh_fp_out[11:1], o_fp_gpio_out[11:1]);
      check_value("o_fp_gpio_ddr", sh_fp_ddr, o_fp_gpio_ddr);
      check_value("o_misc_out", sh_misc, o_misc_out);
      check_value("o_leds", sh_leds, o_leds);
   endtask

   // reference model returning {valid, output word}
   function automatic logic [32:0] predict_rx(input logic [31:0] w);
      logic signed [15:0] si;
      logic signed [15:0] sq;
      logic signed [15:0] tmp;
      longint             energy;
      longint             pi;
      longint             pq;
      logic               valid;
      si = w[31:16];
      sq = w[15:0];
      if (sh_ctrl[`RX_CTRL_SWAP]) begin
         tmp = si;
         si  = sq;
         sq  = tmp;
      end
      if (sh_ctrl[`RX_CTRL_INV_Q])
         sq = 16'(-sq);                   // wraps at -32768
      energy = longint'(si) * longint'(si) + longint'(sq) * longint'(sq);
      valid  = sh_ctrl[`RX_CTRL_RUN] && (energy > longint'(sh_thres));
      pi = (longint'(si) * longint'(sh_scale)) >>> `SCALE_SHIFT;
      pq = (longint'(sq) * longint'(sh_scale)) >>> `SCALE_SHIFT;
      if (valid)
         return {1'b1, pi[15:0], pq[15:0]};
      return {1'b0, si, sq};
   endfunction

   // ----------------------------------------------------------------------
   // row handlers
   // ----------------------------------------------------------------------
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      tick();
      i_set_stb = 1'b0;
      check_pins();                       // pins still show the old settings
      case (addr)
         `SR_RX_CTRL:     sh_ctrl   = data[2:0];
         `SR_SCALE:       sh_scale  = data[15:0];
         `SR_NOISE_THRES: sh_thres  = data;
         `SR_DB_GPIO_OUT: sh_db_out = data;
         `SR_DB_GPIO_DDR: sh_db_ddr = data;
         `SR_FP_GPIO_OUT: sh_fp_out = data[11:0];
         `SR_FP_GPIO_DDR: sh_fp_ddr = data[11:0];
         `SR_MISC_OUT:    sh_misc   = data;
         `SR_LEDS:        sh_leds   = data[2:0];
         default: ;
      endcase
      tick();                             // pins lag the write by 2 cycles
      check_pins();
   endtask

   task automatic read_register(input logic [7:0] addr);
      logic [31:0] exp_word;
      case (addr)
         `RB_DB_GPIO_IN: exp_word = DB_IN;
         `RB_FP_GPIO_IN: exp_word = {20'd0, FP_IN};
         `RB_MISC_IN:    exp_word = MISC_IN;
         `RB_RX_CTRL:    exp_word = {29'd0, sh_ctrl};
         default:        exp_word = '0;
      endcase
      i_rb_stb  = 1'b1;
      i_rb_addr = addr;
      tick();
      i_rb_stb = 1'b0;
      check_value("o_rb_stb", 1, o_rb_stb);
      check_value("o_rb_data", exp_word, o_rb_data);
      tick();
      check_value("o_rb_stb", 0, o_rb_stb);
   endtask

   // cnt samples back to back that must each leave exactly 3 cycles later
   task automatic stream_samples(input int cnt, input logic [31:0] fixed);
      logic [31:0] samples[$];
      logic [32:0] exp_word;
      logic        last_valid;
      int          t;
      int          got;
      last_valid = 1'b0;
      for (int k = 0; k < cnt; k++)
         samples.push_back((cnt == 1) ? fixed : $random(seed));
      t   = 0;
      got = 0;
      while (got < cnt) begin
         if (t < cnt) begin
            i_rx_stb  = 1'b1;
            i_rx_data = samples[t];
         end else begin
            i_rx_stb = 1'b0;
         end
         tick();
         t++;
         if (o_rx_stb) begin
            check_value("o_rx_stb latency", got + 3, t);
            exp_word = predict_rx(samples[got]);
            check_value("o_rx_data", exp_word[31:0], o_rx_data);
            last_valid = exp_word[32];
            got++;
         end
         if (t > cnt + 10)
            fail_timeout("o_rx_stb");
      end
      i_rx_stb = 1'b0;
      // detect flag reaches the pin one register later and holds while idle
      for (int k = 0; k < 3; k++) begin
         tick();
         check_value("o_fp_gpio_out[0]", last_valid, o_fp_gpio_out[0]);
      end
      check_value("o_fp_gpio_out[11:1]", sh_fp_out[11:1], o_fp_gpio_out[11:1]);
   endtask

   task automatic build_table();
      add_row(K_WR, `SR_DB_GPIO_OUT, 32'ha5a5_1234, 0);
      add_row(K_WR, `SR_DB_GPIO_DDR, 32'h0f0f_ff00, 0);
      add_row(K_WR, `SR_FP_GPIO_OUT, 32'h0000_0abe, 0);
      add_row(K_WR, `SR_FP_GPIO_DDR, 32'h0000_0f0f, 0);
      add_row(K_WR, `SR_MISC_OUT,    32'hdead_beef, 0);
      add_row(K_WR, `SR_LEDS,        32'h0000_0005, 0);
      add_row(K_RB, `RB_DB_GPIO_IN,  0, 0);
      add_row(K_RB, `RB_FP_GPIO_IN,  0, 0);
      add_row(K_RB, `RB_MISC_IN,     0, 0);
      add_row(K_RB, 8'd55,           0, 0);   // unmapped
      add_row(K_WR, `SR_RX_CTRL,     32'h0, 0);
      add_row(K_RB, `RB_RX_CTRL,     0, 0);
      add_row(K_RX, 0, 32'h1234_5678, 1);
      add_row(K_RX, 0, 0, 6);
      add_row(K_WR, `SR_RX_CTRL,     32'h2, 0);   // swap
      add_row(K_RX, 0, 0, 4);
      add_row(K_WR, `SR_RX_CTRL,     32'h6, 0);   // swap and invert
      add_row(K_RX, 0, 32'h8000_7fff, 1);
      add_row(K_WR, `SR_RX_CTRL,     32'h4, 0);
      add_row(K_RX, 0, 0, 4);
      add_row(K_WR, `SR_SCALE,       32'h0000_0180, 0);
      add_row(K_WR, `SR_NOISE_THRES, 32'd25, 0);
      add_row(K_WR, `SR_RX_CTRL,     32'h1, 0);
      add_row(K_RB, `RB_RX_CTRL,     0, 0);
      add_row(K_RX, 0, 32'h0003_0004, 1);   // energy equals threshold
      add_row(K_WR, `SR_NOISE_THRES, 32'd24, 0);
      add_row(K_RX, 0, 32'h0003_0004, 1);
      add_row(K_WR, `SR_RX_CTRL,     32'h5, 0);
      add_row(K_WR, `SR_NOISE_THRES, 32'h2000_0000, 0);
      add_row(K_RX, 0, 32'h0000_8000, 1);   // -32768 under inversion
      add_row(K_RX, 0, 0, 8);
      add_row(K_WR, `SR_RX_CTRL,     32'h7, 0);
      add_row(K_RX, 0, 0, 8);
      add_row(K_WR, `SR_SCALE,       32'h0000_ffff, 0);
      add_row(K_RX, 0, 0, 6);
      add_row(K_RX, 0, 32'h0000_0000, 1);   // flag drops again
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      seed         = 32'hc364_8b4f;
      i_arst_n     = 1'b0;
      i_set_stb    = 1'b0;
      i_set_addr   = '0;
      i_set_data   = '0;
      i_rb_stb     = 1'b0;
      i_rb_addr    = '0;
      i_rx_stb     = 1'b0;
      i_rx_data    = '0;
      i_db_gpio_in = DB_IN;
      i_fp_gpio_in = FP_IN;
      i_misc_in    = MISC_IN;
      sh_ctrl      = '0;
      sh_scale     = '0;
      sh_thres     = '0;
      sh_fp_out    = '0;
      sh_db_out    = '0;
      sh_db_ddr    = '0;
      sh_fp_ddr    = '0;
      sh_misc      = '0;
      sh_leds      = '0;
      build_table();

      repeat (2) @(posedge radio_clk);
      #1;
      i_arst_n = 1'b1;
      tick();

      check_value("o_rx_stb", 0, o_rx_stb);
      check_value("o_rb_stb", 0, o_rb_stb);
      check_value("o_leds", 0, o_leds);
      check_value("o_misc_out", 0, o_misc_out);
      check_value("o_db_gpio_out", 0, o_db_gpio_out);
      check_value("o_fp_gpio_out", 0, o_fp_gpio_out);

      foreach (row_kind[r]) begin
         case (row_kind[r])
            K_WR:    write_setting(row_addr[r], row_data[r]);
            K_RB:    read_register(row_addr[r]);
            default: stream_samples(row_cnt[r], row_data[r]);
         endcase
      end

      repeat (2) tick();
      $display("RESULT: PASS");
      $finish;
   end

endmodule : radio_core_tb

`default_nettype wire

//--- verilog/db_settings_regs.sv
// daughterboard settings registers, readback mux, GPIO/misc/LED output registers
`timescale 1ns/1ps
`default_nettype none

`include "radio_defs.svh"

module db_settings_regs (
   input  wire                      radio_clk,
   input  wire                      i_arst_n,
   // settings bus
   input  wire                      i_set_stb,
   input  wire [`SET_ADDR_W-1:0]    i_set_addr,
   input  wire [`SET_DATA_W-1:0]    i_set_data,
   // readback
   input  wire                      i_rb_stb,
   input  wire [`SET_ADDR_W-1:0]    i_rb_addr,
   output logic                     o_rb_stb,
   output logic [`SET_DATA_W-1:0]   o_rb_data,
   // pin inputs
   input  wire  [`GPIO_W-1:0]       i_db_gpio_in,
   input  wire  [`FP_GPIO_W-1:0]    i_fp_gpio_in,
   input  wire  [`GPIO_W-1:0]       i_misc_in,
   input  wire                      i_detect,
   // RX path controls
   output logic                     o_run_rx,
   output logic                     o_swap_iq,
   output logic                     o_invert_q,
   output logic [`IQ_W-1:0]         o_scale_val,
   output logic [`SET_DATA_W-1:0]   o_noise_thres,
   // pin outputs
   output logic [`GPIO_W-1:0]       o_db_gpio_out,
   output logic [`GPIO_W-1:0]       o_db_gpio_ddr,
   output logic [`FP_GPIO_W-1:0]    o_fp_gpio_out,
   output logic [`FP_GPIO_W-1:0]    o_fp_gpio_ddr,
   output logic [`GPIO_W-1:0]       o_misc_out,
   output logic [`LED_W-1:0]        o_leds
);

   logic [2:0]              sr_rx_ctrl;
   logic [`IQ_W-1:0]        sr_scale;
   logic [`SET_DATA_W-1:0]  sr_noise_thres;
   logic [`GPIO_W-1:0]      sr_db_gpio_out;
   logic [`GPIO_W-1:0]      sr_db_gpio_ddr;
   logic [`FP_GPIO_W-1:1]   sr_fp_gpio_out;   // bit 0 belongs to detect
   logic [`FP_GPIO_W-1:0]   sr_fp_gpio_ddr;
   logic [`GPIO_W-1:0]      sr_misc_out;
   logic [`LED_W-1:0]       sr_leds;
   logic [`GPIO_W-1:0]      misc_in_r;
   logic [`SET_DATA_W-1:0]  rb_mux;

   // ----------------------------------------------------------------------
   // register bank
   // ----------------------------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sr_rx_ctrl     <= '0;
         sr_scale       <= '0;
         sr_noise_thres <= '0;
         sr_db_gpio_out <= '0;
         sr_db_gpio_ddr <= '0;
         sr_fp_gpio_out <= '0;
         sr_fp_gpio_ddr <= '0;
         sr_misc_out    <= '0;
         sr_leds        <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            `SR_RX_CTRL:     sr_rx_ctrl     <= i_set_data[2:0];
            `SR_SCALE:       sr_scale       <= i_set_data[`IQ_W-1:0];
            `SR_NOISE_THRES: sr_noise_thres <= i_set_data;
            `SR_DB_GPIO_OUT: sr_db_gpio_out <= i_set_data[`GPIO_W-1:0];
            `SR_DB_GPIO_DDR: sr_db_gpio_ddr <= i_set_data[`GPIO_W-1:0];
            `SR_FP_GPIO_OUT: sr_fp_gpio_out <= i_set_data[`FP_GPIO_W-1:1];
            `SR_FP_GPIO_DDR: sr_fp_gpio_ddr <= i_set_data[`FP_GPIO_W-1:0];
            `SR_MISC_OUT:    sr_misc_out    <= i_set_data[`GPIO_W-1:0];
            `SR_LEDS:        sr_leds        <= i_set_data[`LED_W-1:0];
            default: ;                      // not ours, ignore
         endcase
      end
   end

   // datapath controls come straight off the bank
   assign o_run_rx      = sr_rx_ctrl[`RX_CTRL_RUN];
   assign o_swap_iq     = sr_rx_ctrl[`RX_CTRL_SWAP];
   assign o_invert_q    = sr_rx_ctrl[`RX_CTRL_INV_Q];
   assign o_scale_val   = sr_scale;
   assign o_noise_thres = sr_noise_thres;

   // ----------------------------------------------------------------------
   // pin-facing registers, one more stage toward the pads
   // ----------------------------------------------------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
         o_misc_out    <= '0;
         o_leds        <= '0;
         misc_in_r     <= '0;
      end else begin
         o_db_gpio_out <= sr_db_gpio_out;
         o_db_gpio_ddr <= sr_db_gpio_ddr;
         o_fp_gpio_out <= {sr_fp_gpio_out, i_detect};   // tag detect on pin 0
         o_fp_gpio_ddr <= sr_fp_gpio_ddr;
         o_misc_out    <= sr_misc_out;
         o_leds        <= sr_leds;
         misc_in_r     <= i_misc_in;
      end
   end

   // ----------------------------------------------------------------------
   // readback
   // ----------------------------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         `RB_DB_GPIO_IN: rb_mux = i_db_gpio_in;
         `RB_FP_GPIO_IN: rb_mux = {{(`SET_DATA_W-`FP_GPIO_W){1'b0}}, i_fp_gpio_in};
         `RB_MISC_IN:    rb_mux = misc_in_r;
         `RB_RX_CTRL:    rb_mux = {{(`SET_DATA_W-3){1'b0}}, sr_rx_ctrl};
         default:        rb_mux = '0;         // unknown reads as zero
      endcase
   end

   // answer exactly one cycle after the request
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_rb_stb;
         if (i_rb_stb)
            o_rb_data <= rb_mux;
      end
   end

endmodule : db_settings_regs

`default_nettype wire

//--- verilog/radio_core.sv
// radio datapath top: settings registers, RX front end and tag detector
`timescale 1ns/1ps
`default_nettype none

`include "radio_defs.svh"

module radio_core (
   input  wire                     radio_clk,
   input  wire                     i_arst_n,
   // settings bus
   input  wire                     i_set_stb,
   input  wire [`SET_ADDR_W-1:0]   i_set_addr,
   input  wire [`SET_DATA_W-1:0]   i_set_data,
   input  wire                     i_rb_stb,
   input  wire [`SET_ADDR_W-1:0]   i_rb_addr,
   output wire                     o_rb_stb,
   output wire [`SET_DATA_W-1:0]   o_rb_data,
   // RX stream
   input  wire                     i_rx_stb,
   input  wire [`SAMPLE_W-1:0]     i_rx_data,
   output wire                     o_rx_stb,
   output wire [`SAMPLE_W-1:0]     o_rx_data,
   // pins
   input  wire [`GPIO_W-1:0]       i_db_gpio_in,
   input  wire [`FP_GPIO_W-1:0]    i_fp_gpio_in,
   input  wire [`GPIO_W-1:0]       i_misc_in,
   output wire [`GPIO_W-1:0]       o_db_gpio_out,
   output wire [`GPIO_W-1:0]       o_db_gpio_ddr,
   output wire [`FP_GPIO_W-1:0]    o_fp_gpio_out,
   output wire [`FP_GPIO_W-1:0]    o_fp_gpio_ddr,
   output wire [`GPIO_W-1:0]       o_misc_out,
   output wire [`LED_W-1:0]        o_leds
);

   import radio_pkg::*;

   sample_word_u             rx_word;
   sample_word_u             fe_data;
   sample_word_u             det_data;
   wire                      fe_stb;
   wire                      run_rx;
   wire                      swap_iq;
   wire                      invert_q;
   wire [`IQ_W-1:0]          scale_val;
   wire [`SET_DATA_W-1:0]    noise_thres;
   wire                      detect;

   assign rx_word.raw = i_rx_data;
   assign o_rx_data   = det_data.raw;

   // ----------------------------------------------------------------------
   // settings and pins
   // ----------------------------------------------------------------------
   db_settings_regs u_db_settings_regs (
      .radio_clk     (radio_clk),
      .i_arst_n      (i_arst_n),
      .i_set_stb     (i_set_stb),
      .i_set_addr    (i_set_addr),
      .i_set_data    (i_set_data),
      .i_rb_stb      (i_rb_stb),
      .i_rb_addr     (i_rb_addr),
      .o_rb_stb      (o_rb_stb),
      .o_rb_data     (o_rb_data),
      .i_db_gpio_in  (i_db_gpio_in),
      .i_fp_gpio_in  (i_fp_gpio_in),
      .i_misc_in     (i_misc_in),
      .i_detect      (detect),
      .o_run_rx      (run_rx),
      .o_swap_iq     (swap_iq),
      .o_invert_q    (invert_q),
      .o_scale_val   (scale_val),
      .o_noise_thres (noise_thres),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .o_fp_gpio_out (o_fp_gpio_out),
      .o_fp_gpio_ddr (o_fp_gpio_ddr),
      .o_misc_out    (o_misc_out),
      .o_leds        (o_leds)
   );

   // ----------------------------------------------------------------------
   // RX path, 1 + 2 cycles
   // ----------------------------------------------------------------------
   rx_frontend u_rx_frontend (
      .radio_clk  (radio_clk),
      .i_arst_n   (i_arst_n),
      .i_stb      (i_rx_stb),
      .i_data     (rx_word),
      .i_swap_iq  (swap_iq),
      .i_invert_q (invert_q),
      .o_stb      (fe_stb),
      .o_data     (fe_data)
   );

   tag_rx_detect u_tag_rx_detect (
      .radio_clk     (radio_clk),
      .i_arst_n      (i_arst_n),
      .i_stb         (fe_stb),
      .i_data        (fe_data),
      .i_run_rx      (run_rx),
      .i_scale_val   (scale_val),
      .i_noise_thres (noise_thres),
      .o_stb         (o_rx_stb),
      .o_data        (det_data),
      .o_detect      (detect)       // back to fp gpio bit 0
   );

endmodule : radio_core

`default_nettype wire

//--- verilog/radio_defs.svh
// widths, scale shift, settings and readback address map of the radio
`ifndef RADIO_DEFS_SVH
`define RADIO_DEFS_SVH

// ----------------------------------------------------------------------
// widths
// ----------------------------------------------------------------------
`define SAMPLE_W     32   // one RX word, I and Q packed
`define IQ_W         16
`define SET_ADDR_W   8
`define SET_DATA_W   32
`define GPIO_W       32
`define FP_GPIO_W    12   // front-panel pins
`define LED_W        3    // {RX, TXRX_TX, TXRX_RX}

// fraction bits of the unsigned scale value
`define SCALE_SHIFT  8

// ----------------------------------------------------------------------
// settings bus addresses, daughterboard block starts at 160
// ----------------------------------------------------------------------
`define SR_RX_CTRL       8'd160  // bit0 run_rx, bit1 swap_iq, bit2 invert_q
`define SR_SCALE         8'd161  // low 16 bits
`define SR_NOISE_THRES   8'd162
`define SR_DB_GPIO_OUT   8'd163
`define SR_DB_GPIO_DDR   8'd164
`define SR_FP_GPIO_OUT   8'd165  // bit 0 is overridden by the detect flag
`define SR_FP_GPIO_DDR   8'd166
`define SR_MISC_OUT      8'd167
`define SR_LEDS          8'd168

// RX control bit positions
`define RX_CTRL_RUN      0
`define RX_CTRL_SWAP     1
`define RX_CTRL_INV_Q    2

// ----------------------------------------------------------------------
// readback addresses
// ----------------------------------------------------------------------
`define RB_DB_GPIO_IN    8'd16
`define RB_FP_GPIO_IN    8'd17
`define RB_MISC_IN       8'd18
`define RB_RX_CTRL       8'd19

`endif

//--- verilog/radio_pkg.sv
// radio sample word types: I/Q pair struct and raw/IQ union
`default_nettype none

package radio_pkg;

`include "radio_defs.svh"

   // I in the upper half, Q in the lower half
   typedef struct packed {
      logic signed [`IQ_W-1:0] i;
      logic signed [`IQ_W-1:0] q;
   } iq_pair_t;

   // one RX word, read raw when passed through or selected,
   // read as I/Q when swapped, scaled or squared
   typedef union packed {
      logic [`SAMPLE_W-1:0] raw;
      iq_pair_t             iq;
   } sample_word_u;

endpackage : radio_pkg

`default_nettype wire

//--- verilog/rx_frontend.sv
// RX front-end correction stage with optional I/Q swap and Q inversion
`timescale 1ns/1ps
`default_nettype none

`include "radio_defs.svh"

module rx_frontend (
   input  wire                     radio_clk,
   input  wire                     i_arst_n,
   input  wire                     i_stb,
   input  radio_pkg::sample_word_u i_data,
   input  wire                     i_swap_iq,
   input  wire                     i_invert_q,
   output logic                    o_stb,
   output radio_pkg::sample_word_u o_data
);

   import radio_pkg::*;

   sample_word_u swapped;
   sample_word_u corrected;

   // swap first, then invert whatever ends up in Q
   always_comb begin
      if (i_swap_iq) begin
         swapped.iq.i = i_data.iq.q;
         swapped.iq.q = i_data.iq.i;
      end else begin
         swapped.raw = i_data.raw;
      end

      corrected.iq.i = swapped.iq.i;
      if (i_invert_q)
         corrected.iq.q = -swapped.iq.q;   // -32768 wraps to itself
      else
         corrected.iq.q = swapped.iq.q;
   end

   // strobe follows the input one cycle later
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_stb <= 1'b0;
      else
         o_stb <= i_stb;
   end

   // corrected word registered alongside the strobe
   always_ff @(posedge radio_clk) begin
      o_data <= corrected;
   end

endmodule : rx_frontend

`default_nettype wire

//--- verilog/tag_rx_detect.sv
// tag receive detector: scale and energy stage, threshold compare and output select
`timescale 1ns/1ps
`default_nettype none

`include "radio_defs.svh"

module tag_rx_detect (
   input  wire                     radio_clk,
   input  wire                     i_arst_n,
   input  wire                     i_stb,
   input  radio_pkg::sample_word_u i_data,
   input  wire                     i_run_rx,
   input  wire  [`IQ_W-1:0]        i_scale_val,
   input  wire  [`SET_DATA_W-1:0]  i_noise_thres,
   output logic                    o_stb,
   output radio_pkg::sample_word_u o_data,
   output logic                    o_detect
);

   import radio_pkg::*;

   // signed sample times unsigned scale needs 33 bits
   logic signed [2*`IQ_W:0]   prod_i;
   logic signed [2*`IQ_W:0]   prod_q;
   logic signed [2*`IQ_W:0]   shf_i;
   logic signed [2*`IQ_W:0]   shf_q;

   logic                      s1_stb;
   sample_word_u              s1_word;
   iq_pair_t                  s1_scaled;
   logic [2*`IQ_W-1:0]        s1_sq_i;
   logic [2*`IQ_W-1:0]        s1_sq_q;

   logic [2*`IQ_W-1:0]        energy;
   logic                      valid;

   // ----------------------------------------------------------------------
   // stage 1: squares and scaled products
   // ----------------------------------------------------------------------
   assign prod_i = i_data.iq.i * $signed({1'b0, i_scale_val});
   assign prod_q = i_data.iq.q * $signed({1'b0, i_scale_val});
   assign shf_i  = prod_i >>> `SCALE_SHIFT;   // drop fraction bits
   assign shf_q  = prod_q >>> `SCALE_SHIFT;

   always_ff @(posedge radio_clk) begin
      s1_word      <= i_data;
      s1_scaled.i  <= shf_i[`IQ_W-1:0];        // low 16 bits only
      s1_scaled.q  <= shf_q[`IQ_W-1:0];
      s1_sq_i      <= i_data.iq.i * i_data.iq.i;   // at most 2^30
      s1_sq_q      <= i_data.iq.q * i_data.iq.q;
   end

   // ----------------------------------------------------------------------
   // stage 2: energy, threshold, select
   // ----------------------------------------------------------------------
   assign energy = s1_sq_i + s1_sq_q;          // never wraps, max 2^31
   assign valid  = i_run_rx && (energy > i_noise_thres);

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         s1_stb   <= 1'b0;
         o_stb    <= 1'b0;
         o_data   <= '0;
         o_detect <= 1'b0;
      end else begin
         s1_stb <= i_stb;
         o_stb  <= s1_stb;
         if (s1_stb) begin
            // decision holds until the next sample
            o_detect <= valid;
            if (valid)
               o_data.iq <= s1_scaled;
            else
               o_data.raw <= s1_word.raw;
         end
      end
   end

endmodule : tag_rx_detect

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/radio_pkg.sv
verilog/db_settings_regs.sv
verilog/rx_frontend.sv
verilog/tag_rx_detect.sv
verilog/radio_core.sv
verification/radio_core_sva.sv
verification/radio_core_tb.sv
